// File: project.f
+incdir+.
rms_pkg.sv
rms_frame_store.sv
rms_lane.sv
rms_stat_unit.sv
rms_norm.sv
rms_norm_checker.sv
rms_norm_tb.sv

// File: rms_frame_store.sv
// ==========================================================
// RMS norm frame store: buffers one vector, then issues it
// to the lanes for the square pass and the scale pass
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_frame_store
    import rms_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  beat_t                in_beat,
    input  wire                        in_valid,
    output logic                       in_ready,
    output lane_cmd_t [`RMS_LANES-1:0] lane_cmd,
    input  wire                        lane_ready,
    input  wire                        stat_done,
    output logic                       last_square
);

    localparam int IDX_W = $clog2(`RMS_BEATS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`RMS_BEATS - 1);

    store_state_t     state;
    beat_t            store_q [`RMS_BEATS];
    beat_t            cmd_beat_q;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] next_idx;
    logic             cmd_valid_q;
    logic             scale_q;
    logic             in_fire;

    // Only one vector in flight
    assign in_ready = (state == FILL);
    assign in_fire  = in_valid && in_ready;
    assign next_idx = idx + 1'b1;

    // idx is the write pointer in FILL and the issued beat in REPLAY
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FILL;
            idx         <= '0;
            cmd_valid_q <= 1'b0;
            scale_q     <= 1'b0;
            last_square <= 1'b0;
        end else begin
            last_square <= 1'b0;
            case (state)
                FILL: begin
                    // Square command follows each accepted beat
                    cmd_valid_q <= in_fire;
                    if (in_fire) begin
                        if (idx == LAST_IDX) begin
                            idx         <= '0;
                            last_square <= 1'b1;
                            state       <= WAIT_STAT;
                        end else begin
                            idx <= next_idx;
                        end
                    end
                end
                WAIT_STAT: begin
                    // First scale command goes out with stat_done
                    cmd_valid_q <= stat_done;
                    if (stat_done) begin
                        scale_q <= 1'b1;
                        state   <= REPLAY;
                    end
                end
                REPLAY: begin
                    // Lane took the current command
                    if (lane_ready) begin
                        if (idx == LAST_IDX) begin
                            cmd_valid_q <= 1'b0;
                            state       <= DRAIN;
                        end else begin
                            idx <= next_idx;
                        end
                    end
                end
                DRAIN: begin
                    // Last beat is held in the lanes until it transfers
                    if (lane_ready) begin
                        idx     <= '0;
                        scale_q <= 1'b0;
                        state   <= FILL;
                    end
                end
                default: begin
                    state <= FILL;
                end
            endcase
        end
    end

    // Beat storage and the element part of the command
    always_ff @(posedge clk) begin
        if (in_fire) begin
            store_q[idx] <= in_beat;
            cmd_beat_q   <= in_beat;
        end else if (state == WAIT_STAT && stat_done) begin
            cmd_beat_q <= store_q[0];
        end else if (state == REPLAY && lane_ready && idx != LAST_IDX) begin
            cmd_beat_q <= store_q[next_idx];
        end
    end

    always_comb begin
        for (int i = 0; i < `RMS_LANES; i++) begin
            lane_cmd[i].valid = cmd_valid_q;
            lane_cmd[i].scale = scale_q;
            lane_cmd[i].elem  = cmd_beat_q[i];
        end
    end

endmodule

`default_nettype wire

// File: rms_lane.sv
// ==========================================================
// RMS norm lane: squares one element, or scales it by the
// inverse root with floor and saturation
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_lane
    import rms_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire  lane_cmd_t cmd,
    input  wire  isqrt_t    inv_rms,
    input  wire             out_ready,
    output lane_res_t       res,
    output logic            ready
);

    localparam int SQ_W   = 2 * `RMS_IN_W;
    localparam int PROD_W = `RMS_IN_W + `RMS_ISQ_W + 1;
    localparam int SHIFT  = `RMS_IN_FRAC + `RMS_ISQ_FRAC - `RMS_OUT_FRAC;
    localparam logic signed [PROD_W-1:0] SAT_HI = PROD_W'(2 ** (`RMS_OUT_W - 1) - 1);
    localparam logic signed [PROD_W-1:0] SAT_LO = -SAT_HI - 1;

    logic signed [SQ_W-1:0]   sq_full;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_shr;
    out_elem_t                norm;
    logic                     valid_q;
    logic                     scale_q;
    square_t                  square_q;
    out_elem_t                norm_q;

    // Q.4 square and Q.14 scaled product
    assign sq_full  = cmd.elem * cmd.elem;
    assign prod     = cmd.elem * $signed({1'b0, inv_rms});
    assign prod_shr = prod >>> SHIFT;

    always_comb begin
        if (prod_shr > SAT_HI) begin
            norm = SAT_HI[`RMS_OUT_W-1:0];
        end else if (prod_shr < SAT_LO) begin
            norm = SAT_LO[`RMS_OUT_W-1:0];
        end else begin
            norm = prod_shr[`RMS_OUT_W-1:0];
        end
    end

    // Square results never stall, scaled ones wait for the sink
    assign ready = !(valid_q && scale_q) || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            scale_q <= 1'b0;
        end else if (ready) begin
            valid_q <= cmd.valid;
            scale_q <= cmd.scale;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && cmd.valid) begin
            if (cmd.scale) begin
                norm_q <= norm;
            end else begin
                square_q <= square_t'(sq_full);
            end
        end
    end

    assign res = '{valid: valid_q, square: square_q, elem: norm_q};

endmodule

`default_nettype wire

// File: rms_macros.svh
// ==========================================================
// RMS norm constants: vector shape and fixed-point formats
// ==========================================================

`ifndef RMS_MACROS_SVH
`define RMS_MACROS_SVH

// Vector shape
`define RMS_LANES     4
`define RMS_BEATS     4
// log2 of lanes times beats, used for the mean shift
`define RMS_LOG2_N    4

// Input elements, signed Q5.2
`define RMS_IN_W      8
`define RMS_IN_FRAC   2

// Output elements, signed Q3.4
`define RMS_OUT_W     8
`define RMS_OUT_FRAC  4

// Inverse root, unsigned Q4.12
`define RMS_ISQ_W     16
`define RMS_ISQ_FRAC  12

`endif

// File: rms_norm.sv
// ==========================================================
// RMS norm top: frame store, lane array and statistics unit
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_norm
    import rms_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire  beat_t in_beat,
    input  wire         in_valid,
    output logic        in_ready,
    output out_beat_t   out_beat,
    output logic        out_valid,
    input  wire         out_ready
);

    lane_cmd_t [`RMS_LANES-1:0] lane_cmd;
    lane_res_t [`RMS_LANES-1:0] lane_res;
    isqrt_t                     inv_rms;
    logic                       lane_ready;
    logic                       stat_done;
    logic                       last_square;

    rms_frame_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .lane_cmd    (lane_cmd),
        .lane_ready  (lane_ready),
        .stat_done   (stat_done),
        .last_square (last_square)
    );

    for (genvar i = 0; i < `RMS_LANES; i++) begin : g_lane
        logic ready;

        rms_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd       (lane_cmd[i]),
            .inv_rms   (inv_rms),
            .out_ready (out_ready),
            .res       (lane_res[i]),
            .ready     (ready)
        );

        assign out_beat[i] = lane_res[i].elem;
    end

    // All lanes advance together
    assign lane_ready = g_lane[0].ready;

    // Scale bit stays set through replay and drain
    assign out_valid = lane_res[0].valid && lane_cmd[0].scale;

    rms_stat_unit u_stat (
        .clk         (clk),
        .rst_n       (rst_n),
        .lane_res    (lane_res),
        .last_square (last_square),
        .inv_rms     (inv_rms),
        .stat_done   (stat_done)
    );

endmodule

`default_nettype wire

// File: rms_norm_checker.sv
// ==========================================================
// RMS norm port protocol assertions bound to the top level
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_norm_checker
    import rms_pkg::*;
(
    input wire            clk,
    input wire            rst_n,
    input wire            in_valid,
    input wire            in_ready,
    input wire out_beat_t out_beat,
    input wire            out_valid,
    input wire            out_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] in_cnt;
    logic [2:0] out_cnt;
    logic       pend;
    int         fail_cnt = 0;

    // Tracks one vector from its last input beat to its fourth output beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_cnt  <= '0;
            out_cnt <= '0;
            pend    <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                in_cnt <= (in_cnt == 3'(`RMS_BEATS - 1)) ? '0 : in_cnt + 1'b1;
                if (in_cnt == 3'(`RMS_BEATS - 1)) pend <= 1'b1;
            end
            if (out_valid && out_ready) begin
                out_cnt <= (out_cnt == 3'(`RMS_BEATS - 1)) ? '0 : out_cnt + 1'b1;
                if (out_cnt == 3'(`RMS_BEATS - 1)) pend <= 1'b0;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high during reset");
        end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            fail_cnt++;
            $error("output beat changed under back-pressure");
        end

    a_in_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        pend |-> !in_ready)
        else begin
            fail_cnt++;
            $error("in_ready high while a vector is in flight");
        end

    a_out_owned: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> pend)
        else begin
            fail_cnt++;
            $error("output transfer beyond four beats of a vector");
        end

endmodule

`default_nettype wire

// File: rms_norm_tb.sv
// ==========================================================
// RMS norm testbench with random and directed vectors
// checked against a fixed-point model of the normalization
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_norm_tb
    import rms_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `RMS_LANES * `RMS_BEATS;

    logic      clk;
    logic      rst_n;
    beat_t     in_beat;
    logic      in_valid;
    logic      in_ready;
    out_beat_t out_beat;
    logic      out_valid;
    logic      out_ready;
    logic      toggle_en;

    out_beat_t exp_q[$];
    isqrt_t    exp_isq;
    int        errors;
    int        tests_run;
    int        tests_bad;
    int        vectors_done;
    int        cyc;
    int        in_cnt;
    int        out_cnt;
    int        last_in_cyc;
    bit        busy;
    bit        drained_prev;
    bit        first_seen;
    bit        timed_out;

    rms_norm dut (.*);

    bind rms_norm rms_norm_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random back-pressure when enabled
    always @(posedge clk) begin : drive_ready
        logic next_ready;
        next_ready = toggle_en ? 1'($urandom % 2) : 1'b1;
        #1 out_ready = next_ready;
    end

    // Reference model of squares, mean, inverse root and outputs
    function automatic void model_push(input elem_t v[N]);
        longint sum;
        longint mean;
        longint r;
        longint p;
        out_beat_t ob;
        sum = 0;
        for (int i = 0; i < N; i++) sum += longint'(v[i]) * longint'(v[i]);
        mean = sum >> `RMS_LOG2_N;
        if (mean == 0) begin
            r = 65535;
        end else begin
            r = longint'($floor($sqrt(268435456.0 / real'(mean))));
            if (r > 65535) r = 65535;
            while (r * r * mean > 64'd268435456) r--;
            while (r < 65535 && (r + 1) * (r + 1) * mean <= 64'd268435456) r++;
        end
        exp_isq = isqrt_t'(r);
        for (int b = 0; b < `RMS_BEATS; b++) begin
            for (int l = 0; l < `RMS_LANES; l++) begin
                p = (longint'(v[b * `RMS_LANES + l]) * r) >>> 10;
                if (p > 127) p = 127;
                if (p < -128) p = -128;
                ob[l] = out_elem_t'(p);
            end
            exp_q.push_back(ob);
        end
    endfunction

    // Monitor errors plus failures of the bound protocol assertions
    function automatic int error_total();
        return errors + dut.u_checker.fail_cnt;
    endfunction

    task automatic flag_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    // Sends one vector and waits until all four output beats are taken
    task automatic run_vector(input elem_t v[N], input bit gaps);
        beat_t b;
        int    t;
        int    base;
        if (timed_out) begin
            return;
        end
        model_push(v);
        base = vectors_done;
        for (int k = 0; k < `RMS_BEATS; k++) begin
            if (gaps) begin
                in_valid = 1'b0;
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                    #1;
                end
            end
            for (int l = 0; l < `RMS_LANES; l++) b[l] = v[k * `RMS_LANES + l];
            in_beat  = b;
            in_valid = 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!in_ready && t < 100);
            if (!in_ready) begin
                flag_timeout("in_ready never rose for an input beat");
                return;
            end
            #1 in_valid = 1'b0;
        end
        t = 0;
        while (vectors_done == base && t < 300) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (vectors_done == base) begin
            flag_timeout("output beats of a vector never completed");
        end
    endtask

    task automatic report(input string name, input int err_before);
        int err_now;
        err_now = error_total();
        tests_run++;
        if (err_now != err_before) tests_bad++;
        $display("%-28s %s", name, (err_now == err_before) ? "ok" : "FAIL");
    endtask

    // Ordering, latency and data checks at the ports
    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            a_ready_low: assert (!(busy && in_ready)) else begin
                errors++;
                $display("ERROR %0t in_ready exp 0 got 1", $time);
            end
            if (drained_prev) begin
                a_ready_back: assert (in_ready) else begin
                    errors++;
                    $display("ERROR %0t in_ready exp 1 got 0", $time);
                end
                drained_prev = 1'b0;
            end
            if (in_valid && in_ready) begin
                in_cnt++;
                if (in_cnt == `RMS_BEATS) begin
                    in_cnt      = 0;
                    busy        = 1'b1;
                    first_seen  = 1'b0;
                    last_in_cyc = cyc;
                end
            end
            if (out_valid && !first_seen && busy) begin
                first_seen = 1'b1;
                a_latency: assert (cyc - 1 - last_in_cyc == 21) else begin
                    errors++;
                    $display("ERROR %0t out_valid latency exp 21 got %0d",
                             $time, cyc - 1 - last_in_cyc);
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output beat transferred with no vector pending at %0t", $time);
                end else begin
                    a_data: assert (out_beat == exp_q[0]) else begin
                        errors++;
                        $display("ERROR %0t out_beat exp %h got %h", $time, exp_q[0], out_beat);
                    end
                    void'(exp_q.pop_front());
                end
                a_isq: assert (dut.inv_rms == exp_isq) else begin
                    errors++;
                    $display("ERROR %0t inv_rms exp %h got %h", $time, exp_isq, dut.inv_rms);
                end
                out_cnt++;
                if (out_cnt == `RMS_BEATS) begin
                    out_cnt      = 0;
                    busy         = 1'b0;
                    drained_prev = 1'b1;
                    vectors_done++;
                end
            end
        end
    end

    initial begin
        elem_t v[N];
        int    e0;
        void'($urandom(32'h0630_b8d8));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        out_ready = 1'b1;
        toggle_en = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        vectors_done = 0;
        cyc = 0;
        in_cnt = 0;
        out_cnt = 0;
        last_in_cyc = 0;
        busy = 1'b0;
        drained_prev = 1'b0;
        first_seen = 1'b0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        e0 = error_total();
        for (int n = 0; n < 6; n++) begin
            foreach (v[i]) v[i] = elem_t'($urandom);
            run_vector(v, 1'b0);
        end
        report("random vectors", e0);

        e0 = error_total();
        foreach (v[i]) v[i] = '0;
        run_vector(v, 1'b0);
        report("zero vector", e0);

        e0 = error_total();
        foreach (v[i]) v[i] = 8'sd127;
        run_vector(v, 1'b0);
        foreach (v[i]) v[i] = -8'sd128;
        run_vector(v, 1'b0);
        // Small sums floor to a zero mean and push the outputs past full scale
        foreach (v[i]) v[i] = (i == 5) ? 8'sd3 : 8'sd0;
        run_vector(v, 1'b0);
        foreach (v[i]) v[i] = (i == 10) ? -8'sd3 : 8'sd0;
        run_vector(v, 1'b0);
        report("large magnitudes", e0);

        e0 = error_total();
        toggle_en = 1'b1;
        for (int n = 0; n < 4; n++) begin
            foreach (v[i]) v[i] = elem_t'($urandom);
            run_vector(v, 1'b0);
        end
        toggle_en = 1'b0;
        report("output back-pressure", e0);

        e0 = error_total();
        for (int n = 0; n < 4; n++) begin
            foreach (v[i]) v[i] = elem_t'($urandom);
            run_vector(v, 1'b1);
        end
        report("input gaps", e0);

        e0 = error_total();
        foreach (v[i]) v[i] = elem_t'($urandom);
        run_vector(v, 1'b1);
        repeat (2) @(posedge clk);
        report("in_ready hold and release", e0);

        $display("tests %0d, failing tests %0d, errors %0d",
                 tests_run, tests_bad, error_total());
        if (error_total() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rms_pkg.sv
// ==========================================================
// RMS norm types shared by the datapath and the testbench
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

package rms_pkg;

    // Scalar formats
    typedef logic signed [`RMS_IN_W-1:0]                 elem_t;
    typedef logic        [2*`RMS_IN_W-1:0]               square_t;
    typedef logic        [2*`RMS_IN_W+`RMS_LOG2_N-1:0]   sum_t;
    typedef logic        [`RMS_ISQ_W-1:0]                isqrt_t;
    typedef logic signed [`RMS_OUT_W-1:0]                out_elem_t;

    // One beat on each port
    typedef elem_t     [`RMS_LANES-1:0] beat_t;
    typedef out_elem_t [`RMS_LANES-1:0] out_beat_t;

    // Frame store to lane
    typedef struct packed {
        logic  valid;
        logic  scale;
        elem_t elem;
    } lane_cmd_t;

    // Lane back to stats and output port
    typedef struct packed {
        logic      valid;
        square_t   square;
        out_elem_t elem;
    } lane_res_t;

    typedef enum logic [1:0] {FILL, WAIT_STAT, REPLAY, DRAIN} store_state_t;
    typedef enum logic [1:0] {ACCUM, MEAN, SEARCH, HOLD} stat_state_t;

endpackage

`default_nettype wire

// File: rms_stat_unit.sv
// ==========================================================
// RMS norm statistics: sum of squares, mean, and a bit-serial
// inverse square root search
// ==========================================================

`default_nettype none

`include "rms_macros.svh"

module rms_stat_unit
    import rms_pkg::*;
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  lane_res_t [`RMS_LANES-1:0] lane_res,
    input  wire                             last_square,
    output isqrt_t                          inv_rms,
    output logic                            stat_done
);

    localparam int TRIAL_SQ_W = 2 * `RMS_ISQ_W;
    localparam int CHECK_W    = TRIAL_SQ_W + $bits(sum_t);
    localparam int BIT_W      = $clog2(`RMS_ISQ_W);
    // 1.0 with r^2 fraction plus mean fraction bits
    localparam logic [CHECK_W-1:0] BOUND =
        CHECK_W'(1) << (2 * `RMS_ISQ_FRAC + 2 * `RMS_IN_FRAC);

    stat_state_t             state;
    sum_t                    acc;
    sum_t                    beat_sum;
    sum_t                    mean_q;
    isqrt_t                  root_q;
    isqrt_t                  trial;
    logic [TRIAL_SQ_W-1:0]   trial_sq;
    logic [CHECK_W-1:0]      check;
    logic [BIT_W-1:0]        bit_idx;
    logic                    beat_valid;
    logic                    last_q;
    logic                    res_valid_q;

    // Adder across the lanes
    always_comb begin
        beat_sum   = '0;
        beat_valid = 1'b0;
        for (int i = 0; i < `RMS_LANES; i++) begin
            if (lane_res[i].valid) begin
                beat_sum   = beat_sum + sum_t'(lane_res[i].square);
                beat_valid = 1'b1;
            end
        end
    end

    // Try the current bit on top of the bits kept so far
    assign trial    = root_q | (isqrt_t'(1) << bit_idx);
    assign trial_sq = trial * trial;
    assign check    = trial_sq * mean_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ACCUM;
            acc         <= '0;
            root_q      <= '0;
            bit_idx     <= '0;
            stat_done   <= 1'b0;
            last_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            stat_done   <= 1'b0;
            // Delayed to line up with the last lane result
            last_q      <= last_square;
            res_valid_q <= lane_res[0].valid;
            case (state)
                ACCUM: begin
                    if (beat_valid) begin
                        acc <= acc + beat_sum;
                    end
                    if (last_q) begin
                        state <= MEAN;
                    end
                end
                MEAN: begin
                    root_q  <= '0;
                    bit_idx <= BIT_W'(`RMS_ISQ_W - 1);
                    state   <= SEARCH;
                end
                SEARCH: begin
                    // Zero mean keeps every bit
                    if (check <= BOUND) begin
                        root_q <= trial;
                    end
                    if (bit_idx == '0) begin
                        stat_done <= 1'b1;
                        state     <= HOLD;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                HOLD: begin
                    // Scaled results have drained, next vector may start
                    if (res_valid_q && !lane_res[0].valid) begin
                        acc   <= '0;
                        state <= ACCUM;
                    end
                end
                default: begin
                    state <= ACCUM;
                end
            endcase
        end
    end

    // Divide by the element count, floor
    always_ff @(posedge clk) begin
        if (state == MEAN) begin
            mean_q <= acc >> `RMS_LOG2_N;
        end
    end

    assign inv_rms = root_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the RMS norm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module rms_norm_tb -o rms_norm_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rms_norm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
